//--- back_end.f
source/back_end_pkg.sv
source/dispatch.sv
source/issue_fifo.sv
source/alu_issue.sv
source/alu.sv
source/phy_register.sv
source/commit.sv
source/back_end.sv
testbench/back_end_tb.sv

//--- testbench/back_end_tb.sv
// back end testbench
`timescale 1ns/1ps

module back_end_tb;

	localparam int MAX_PROG = 128;
	// program length plus the refetch after the flush
	localparam int N_INSTR = 88;
	localparam int WATCHDOG_CYCLES = N_INSTR * 60 + 16;

	logic CLK;
	logic i_arst_n;
	back_end_pkg::micro_instr_t i_decode_micro_instr;
	logic i_instr_fifo_empty;
	logic o_instr_fifo_pop;
	logic i_is_mispredict;
	logic o_is_flush;
	logic o_commit_valid;
	back_end_pkg::areg_t o_commit_rd;
	back_end_pkg::data_t o_commit_data;

	back_end_pkg::micro_instr_t prog [MAX_PROG];
	back_end_pkg::data_t ref_regs [back_end_pkg::NREG];
	int prog_len;
	int src_idx;
	int commit_idx;
	int errors;
	int err_before;
	int tests_passed;
	int tests_failed;
	logic [31:0] seed;

	// next expected commit from the in-order model
	logic exp_valid;
	back_end_pkg::micro_instr_t exp_instr;
	back_end_pkg::areg_t exp_rd;
	back_end_pkg::data_t exp_data;

	back_end uut (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_decode_micro_instr(i_decode_micro_instr),
		.i_instr_fifo_empty(i_instr_fifo_empty),
		.o_instr_fifo_pop(o_instr_fifo_pop),
		.i_is_mispredict(i_is_mispredict),
		.o_is_flush(o_is_flush),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	always #20 CLK = ~CLK;

	function automatic back_end_pkg::data_t expected_result(
		back_end_pkg::micro_instr_t mi, back_end_pkg::data_t a, back_end_pkg::data_t b);
		case (mi.op)
			back_end_pkg::op_add:  return a + b;
			back_end_pkg::op_sub:  return a - b;
			back_end_pkg::op_and:  return a & b;
			back_end_pkg::op_or:   return a | b;
			back_end_pkg::op_xor:  return a ^ b;
			back_end_pkg::op_addi: return a + mi.imm;
			default:               return '0;
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always_comb begin
		exp_valid = (commit_idx < prog_len);
		exp_instr = prog[commit_idx];
		exp_rd = exp_instr.rd;
		// x0 reads and writes as zero
		exp_data = (exp_instr.rd == '0) ? '0
			: expected_result(exp_instr, ref_regs[exp_instr.rs1], ref_regs[exp_instr.rs2]);
	end

	commit_in_program: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_commit_valid |-> exp_valid)
		else begin
			$display("commit seen with no instruction left in the program");
			errors++;
		end

	commit_rd_check: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_commit_valid && exp_valid |-> o_commit_rd == exp_rd)
		else begin
			$display("[FAIL] o_commit_rd got %h expected %h", $sampled(o_commit_rd),
				$sampled(exp_rd));
			errors++;
		end

	commit_data_check: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_commit_valid && exp_valid |-> o_commit_data == exp_data)
		else begin
			$display("[FAIL] o_commit_data got %h expected %h", $sampled(o_commit_data),
				$sampled(exp_data));
			errors++;
		end

	no_commit_on_flush: assert property (@(posedge CLK) disable iff (!i_arst_n)
		o_is_flush |-> !o_commit_valid)
		else begin
			$display("instruction retired in the flush cycle");
			errors++;
		end

	task automatic drive_source();
		i_instr_fifo_empty = (src_idx >= prog_len);
		i_decode_micro_instr = (src_idx < prog_len) ? prog[src_idx] : '0;
	endtask

	task automatic add_instr(back_end_pkg::alu_op_e op, int rd, int rs1, int rs2,
		back_end_pkg::data_t imm);
		prog[prog_len] = {op, 3'(rd), 3'(rs1), 3'(rs2), imm};
		prog_len++;
	endtask

	task automatic add_random(int count, int hot_reg);
		back_end_pkg::data_t imm;
		for (int i = 0; i < count; i++) begin
			seed = lcg_next(seed);
			imm = lcg_next(seed);
			// every third one writes the same register
			add_instr(back_end_pkg::alu_op_e'(seed[31:16] % 6),
				(i % 3 == 0) ? hot_reg : int'(seed[15:13]), seed[12:10], seed[9:7], imm);
		end
	endtask

	// sample at negedge and update 2 ns after posedge
	task automatic step();
		logic pop_s;
		logic cm_s;
		back_end_pkg::areg_t rd_s;
		back_end_pkg::data_t data_s;
		@(negedge CLK);
		pop_s = o_instr_fifo_pop;
		cm_s = o_commit_valid;
		rd_s = exp_rd;
		data_s = exp_data;
		@(posedge CLK);
		#2;
		if (pop_s) begin
			src_idx++;
		end
		if (cm_s) begin
			if (rd_s != '0) begin
				ref_regs[rd_s] = data_s;
			end
			commit_idx++;
		end
		drive_source();
	endtask

	task automatic run_program();
		drive_source();
		while (commit_idx < prog_len) begin
			step();
		end
	endtask

	task automatic check_idle();
		@(negedge CLK);
		assert (o_instr_fifo_pop == 1'b0 && o_commit_valid == 1'b0 && o_is_flush == 1'b0)
			else begin
				$display("[FAIL] pop/commit/flush got %h%h%h expected 000",
					o_instr_fifo_pop, o_commit_valid, o_is_flush);
				errors++;
			end
		@(posedge CLK);
		#2;
	endtask

	task automatic flush_pulse();
		i_is_mispredict = 1'b1;
		@(negedge CLK);
		assert (o_is_flush == 1'b1)
			else begin
				$display("[FAIL] o_is_flush got %h expected %h", o_is_flush, 1'b1);
				errors++;
			end
		@(posedge CLK);
		#2;
		i_is_mispredict = 1'b0;
		// refetch from the first uncommitted instruction
		src_idx = commit_idx;
		drive_source();
	endtask

	task automatic finish_test(string name);
		if (errors == err_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
		err_before = errors;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 40);
		$display("timeout, the back end stopped committing instructions");
		$display("Test failures found");
		$finish;
	end

	initial begin
		CLK = 1'b0;
		i_arst_n = 1'b0;
		i_decode_micro_instr = '0;
		i_instr_fifo_empty = 1'b1;
		i_is_mispredict = 1'b0;
		prog_len = 0;
		src_idx = 0;
		commit_idx = 0;
		errors = 0;
		err_before = 0;
		tests_passed = 0;
		tests_failed = 0;
		seed = 32'd31840;
		for (int r = 0; r < back_end_pkg::NREG; r++) begin
			ref_regs[r] = '0;
		end
		repeat (16) @(posedge CLK);
		#2;
		i_arst_n = 1'b1;

		check_idle();
		add_instr(back_end_pkg::op_add, 1, 2, 3, 0);
		add_instr(back_end_pkg::op_or, 4, 5, 6, 0);
		run_program();
		finish_test("reset");

		add_instr(back_end_pkg::op_addi, 1, 0, 0, 32'h1234_5678);
		add_instr(back_end_pkg::op_addi, 2, 0, 0, 32'hf0f0_0ff1);
		add_instr(back_end_pkg::op_add, 3, 1, 2, 0);
		add_instr(back_end_pkg::op_sub, 4, 1, 2, 0);
		add_instr(back_end_pkg::op_and, 5, 1, 2, 0);
		add_instr(back_end_pkg::op_or, 6, 1, 2, 0);
		add_instr(back_end_pkg::op_xor, 7, 1, 2, 0);
		run_program();
		finish_test("opcodes");

		// each one needs the result right before it
		add_instr(back_end_pkg::op_addi, 1, 1, 0, 32'h0000_0001);
		add_instr(back_end_pkg::op_add, 1, 1, 1, 0);
		add_instr(back_end_pkg::op_sub, 1, 1, 2, 0);
		add_instr(back_end_pkg::op_xor, 1, 1, 3, 0);
		add_instr(back_end_pkg::op_addi, 1, 1, 0, 32'hffff_fff0);
		add_instr(back_end_pkg::op_and, 1, 1, 4, 0);
		run_program();
		finish_test("dependency chain");

		add_random(40, 3);
		run_program();
		// source stays empty so any further commit is spurious
		repeat (8) @(posedge CLK);
		#2;
		finish_test("random stream");

		add_random(16, 5);
		drive_source();
		while (commit_idx < prog_len - 12) begin
			step();
		end
		flush_pulse();
		run_program();
		finish_test("mispredict flush");

		add_instr(back_end_pkg::op_addi, 0, 1, 0, 32'h0000_0005);
		add_instr(back_end_pkg::op_add, 0, 2, 3, 0);
		add_instr(back_end_pkg::op_add, 4, 0, 0, 0);
		add_instr(back_end_pkg::op_or, 5, 0, 1, 0);
		add_instr(back_end_pkg::op_addi, 6, 0, 0, 32'h0000_0007);
		run_program();
		finish_test("x0 writes");

		$display("tests passed %0d, tests failed %0d, errors %0d", tests_passed,
			tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- source/back_end.sv
// out-of-order integer back end
`timescale 1ns/1ps

module back_end (
	input  logic CLK,
	input  logic i_arst_n,
	input  back_end_pkg::micro_instr_t i_decode_micro_instr,
	input  logic i_instr_fifo_empty,
	output logic o_instr_fifo_pop,
	input  logic i_is_mispredict,
	output logic o_is_flush,
	output logic o_commit_valid,
	output back_end_pkg::areg_t o_commit_rd,
	output back_end_pkg::data_t o_commit_data
);

	back_end_pkg::data_t [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] reg_file;
	back_end_pkg::copy_t [back_end_pkg::NREG-1:0] rn_act;
	logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] rn_busy;
	logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] wb_log;
	back_end_pkg::rename_set_t rename_set;

	// dispatch to queues
	logic iq_push;
	logic iq_full;
	logic iq_pop;
	logic iq_empty;
	back_end_pkg::issue_info_t iq_in;
	back_end_pkg::issue_info_t iq_head;
	logic rob_push;
	logic rob_full;
	logic rob_pop;
	logic rob_empty;
	back_end_pkg::reorder_info_t rob_in;
	back_end_pkg::reorder_info_t rob_head;

	// issue, execute and write-back
	logic exe_valid;
	back_end_pkg::exe_param_t exe_param;
	logic wb_valid;
	back_end_pkg::phy_idx_t wb_rd;
	back_end_pkg::data_t wb_res;

	dispatch u_dispatch (
		.i_decode_micro_instr(i_decode_micro_instr),
		.i_instr_fifo_empty(i_instr_fifo_empty),
		.o_instr_fifo_pop(o_instr_fifo_pop),
		.i_rn_act(rn_act),
		.i_rn_busy(rn_busy),
		.o_rename_set(rename_set),
		.o_issue_push(iq_push),
		.o_issue_info(iq_in),
		.i_issue_full(iq_full),
		.o_rob_push(rob_push),
		.o_rob_info(rob_in),
		.i_rob_full(rob_full)
	);

	issue_fifo #(.DW($bits(back_end_pkg::issue_info_t)), .AW(back_end_pkg::IQ_AW)) iq_fifo (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_flush(o_is_flush),
		.i_push(iq_push),
		.i_data(iq_in),
		.i_pop(iq_pop),
		.o_data(iq_head),
		.o_empty(iq_empty),
		.o_full(iq_full)
	);

	issue_fifo #(.DW($bits(back_end_pkg::reorder_info_t)), .AW(back_end_pkg::ROB_AW)) rob_fifo (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_flush(o_is_flush),
		.i_push(rob_push),
		.i_data(rob_in),
		.i_pop(rob_pop),
		.o_data(rob_head),
		.o_empty(rob_empty),
		.o_full(rob_full)
	);

	alu_issue u_alu_issue (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_flush(o_is_flush),
		.i_empty(iq_empty),
		.i_issue_info(iq_head),
		.o_pop(iq_pop),
		.i_wb_log(wb_log),
		.i_reg_file(reg_file),
		.o_exe_valid(exe_valid),
		.o_exe_param(exe_param)
	);

	alu u_alu (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_flush(o_is_flush),
		.i_exe_valid(exe_valid),
		.i_exe_param(exe_param),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_res(wb_res)
	);

	// architectural map stays inside the register block
	phy_register u_phy_register (
		.CLK(CLK),
		.i_arst_n(i_arst_n),
		.i_flush(o_is_flush),
		.i_rename_set(rename_set),
		.i_wb_valid(wb_valid),
		.i_wb_rd(wb_rd),
		.i_wb_res(wb_res),
		.i_commit_valid(o_commit_valid),
		.i_commit_info(rob_head),
		.o_reg_file(reg_file),
		.o_rn_act(rn_act),
		.o_rn_busy(rn_busy),
		.o_wb_log(wb_log),
		.o_archi()
	);

	commit u_commit (
		.i_rob_empty(rob_empty),
		.i_rob_info(rob_head),
		.o_rob_pop(rob_pop),
		.i_wb_log(wb_log),
		.i_reg_file(reg_file),
		.i_is_mispredict(i_is_mispredict),
		.o_commit_valid(o_commit_valid),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data),
		.o_is_flush(o_is_flush)
	);

endmodule

//--- source/commit.sv
// in-order commit stage
`timescale 1ns/1ps

module commit (
	input  logic i_rob_empty,
	input  back_end_pkg::reorder_info_t i_rob_info,
	output logic o_rob_pop,
	input  logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] i_wb_log,
	input  back_end_pkg::data_t [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] i_reg_file,
	input  logic i_is_mispredict,
	output logic o_commit_valid,
	output back_end_pkg::areg_t o_commit_rd,
	output back_end_pkg::data_t o_commit_data,
	output logic o_is_flush
);

	logic head_done;

	// head has been written back
	assign head_done = i_wb_log[i_rob_info.rd][i_rob_info.rd_copy];

	// a mispredict blocks retire in its own cycle
	assign o_commit_valid = !i_rob_empty && head_done && !i_is_mispredict;
	assign o_rob_pop = o_commit_valid;

	assign o_commit_rd = i_rob_info.rd;
	assign o_commit_data = i_reg_file[i_rob_info.rd][i_rob_info.rd_copy];

	assign o_is_flush = i_is_mispredict;

endmodule

//--- source/phy_register.sv
// physical register file and rename maps
`timescale 1ns/1ps

module phy_register (
	input  logic CLK,
	input  logic i_arst_n,
	input  logic i_flush,
	input  back_end_pkg::rename_set_t i_rename_set,
	input  logic i_wb_valid,
	input  back_end_pkg::phy_idx_t i_wb_rd,
	input  back_end_pkg::data_t i_wb_res,
	input  logic i_commit_valid,
	input  back_end_pkg::reorder_info_t i_commit_info,
	output back_end_pkg::data_t [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] o_reg_file,
	output back_end_pkg::copy_t [back_end_pkg::NREG-1:0] o_rn_act,
	output logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] o_rn_busy,
	output logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] o_wb_log,
	output back_end_pkg::copy_t [back_end_pkg::NREG-1:0] o_archi
);

	// one-hot of the architectural copy per register
	logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] arch_mask;
	back_end_pkg::areg_t cm_rd;
	logic wb_en;

	assign cm_rd = i_commit_info.rd;
	// register 0 stays zero
	assign wb_en = i_wb_valid && (i_wb_rd.areg != '0);

	always_comb begin
		for (int r = 0; r < back_end_pkg::NREG; r++) begin
			arch_mask[r] = '0;
			arch_mask[r][o_archi[r]] = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_reg_file <= '0;
			o_rn_act <= '0;
			o_archi <= '0;
			o_rn_busy <= '0;
			o_wb_log <= '0;
			for (int r = 0; r < back_end_pkg::NREG; r++) begin
				o_rn_busy[r][0] <= 1'b1;
				o_wb_log[r][0] <= 1'b1;
			end
		end else begin
			if (wb_en) begin
				o_reg_file[i_wb_rd.areg][i_wb_rd.copy] <= i_wb_res;
			end
			if (i_flush) begin
				// roll back to the committed state
				o_rn_act <= o_archi;
				o_rn_busy <= arch_mask;
				o_wb_log <= o_wb_log & arch_mask;
			end else begin
				if (i_rename_set.valid) begin
					o_rn_act[i_rename_set.phy.areg] <= i_rename_set.phy.copy;
					o_rn_busy[i_rename_set.phy.areg][i_rename_set.phy.copy] <= 1'b1;
				end
				if (wb_en) begin
					o_wb_log[i_wb_rd.areg][i_wb_rd.copy] <= 1'b1;
				end
				// old architectural copy is released on retire
				if (i_commit_valid && (cm_rd != '0)) begin
					o_rn_busy[cm_rd][o_archi[cm_rd]] <= 1'b0;
					o_wb_log[cm_rd][o_archi[cm_rd]] <= 1'b0;
					o_archi[cm_rd] <= i_commit_info.rd_copy;
				end
			end
		end
	end

endmodule

//--- source/alu.sv
// integer ALU
`timescale 1ns/1ps

module alu (
	input  logic CLK,
	input  logic i_arst_n,
	input  logic i_flush,
	input  logic i_exe_valid,
	input  back_end_pkg::exe_param_t i_exe_param,
	output logic o_wb_valid,
	output back_end_pkg::phy_idx_t o_wb_rd,
	output back_end_pkg::data_t o_wb_res
);

	back_end_pkg::data_t res;

	// sums wrap modulo 2^32
	always_comb begin
		case (i_exe_param.op)
			back_end_pkg::op_add,
			back_end_pkg::op_addi: res = i_exe_param.src1 + i_exe_param.src2;
			back_end_pkg::op_sub:  res = i_exe_param.src1 - i_exe_param.src2;
			back_end_pkg::op_and:  res = i_exe_param.src1 & i_exe_param.src2;
			back_end_pkg::op_or:   res = i_exe_param.src1 | i_exe_param.src2;
			back_end_pkg::op_xor:  res = i_exe_param.src1 ^ i_exe_param.src2;
			default:               res = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_valid <= 1'b0;
		end else if (i_flush) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_exe_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_exe_valid) begin
			o_wb_rd <= i_exe_param.rd_phy;
			o_wb_res <= res;
		end
	end

endmodule

//--- source/alu_issue.sv
// ALU issue stage
`timescale 1ns/1ps

module alu_issue (
	input  logic CLK,
	input  logic i_arst_n,
	input  logic i_flush,
	input  logic i_empty,
	input  back_end_pkg::issue_info_t i_issue_info,
	output logic o_pop,
	input  logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] i_wb_log,
	input  back_end_pkg::data_t [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] i_reg_file,
	output logic o_exe_valid,
	output back_end_pkg::exe_param_t o_exe_param
);

	logic use_imm;
	logic rs1_ready;
	logic rs2_ready;

	assign use_imm = (i_issue_info.op == back_end_pkg::op_addi);

	// operand is ready once its copy is written back
	assign rs1_ready = i_wb_log[i_issue_info.rs1_phy.areg][i_issue_info.rs1_phy.copy];
	assign rs2_ready = use_imm
		|| i_wb_log[i_issue_info.rs2_phy.areg][i_issue_info.rs2_phy.copy];

	// head only, so issue stays in order
	assign o_pop = !i_empty && rs1_ready && rs2_ready;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_exe_valid <= 1'b0;
		end else if (i_flush) begin
			o_exe_valid <= 1'b0;
		end else begin
			o_exe_valid <= o_pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (o_pop) begin
			o_exe_param.op <= i_issue_info.op;
			o_exe_param.rd_phy <= i_issue_info.rd_phy;
			o_exe_param.src1 <= i_reg_file[i_issue_info.rs1_phy.areg][i_issue_info.rs1_phy.copy];
			o_exe_param.src2 <= use_imm ? i_issue_info.imm
				: i_reg_file[i_issue_info.rs2_phy.areg][i_issue_info.rs2_phy.copy];
		end
	end

endmodule

//--- source/issue_fifo.sv
// circular FIFO with flush
`timescale 1ns/1ps

module issue_fifo #(
	parameter int DW = 8,
	parameter int AW = 2
) (
	input  logic CLK,
	input  logic i_arst_n,
	input  logic i_flush,
	input  logic i_push,
	input  logic [DW-1:0] i_data,
	input  logic i_pop,
	output logic [DW-1:0] o_data,
	output logic o_empty,
	output logic o_full
);

	logic [DW-1:0] mem [2**AW];
	// extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign o_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push && !o_full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop && !o_empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push && !o_full) begin
			mem[wr_ptr[AW-1:0]] <= i_data;
		end
	end

endmodule

//--- source/dispatch.sv
// rename and dispatch stage
`timescale 1ns/1ps

module dispatch (
	input  back_end_pkg::micro_instr_t i_decode_micro_instr,
	input  logic i_instr_fifo_empty,
	output logic o_instr_fifo_pop,
	input  back_end_pkg::copy_t [back_end_pkg::NREG-1:0] i_rn_act,
	input  logic [back_end_pkg::NREG-1:0][back_end_pkg::RP-1:0] i_rn_busy,
	output back_end_pkg::rename_set_t o_rename_set,
	output logic o_issue_push,
	output back_end_pkg::issue_info_t o_issue_info,
	input  logic i_issue_full,
	output logic o_rob_push,
	output back_end_pkg::reorder_info_t o_rob_info,
	input  logic i_rob_full
);

	back_end_pkg::micro_instr_t instr;
	back_end_pkg::copy_t free_copy;
	logic free_found;
	logic rd_en;

	assign instr = i_decode_micro_instr;
	// x0 never gets a new copy
	assign rd_en = (instr.rd != '0);

	// priority search, lowest free copy of rd wins
	always_comb begin
		free_copy = '0;
		free_found = 1'b0;
		for (int c = back_end_pkg::RP - 1; c >= 0; c--) begin
			if (!i_rn_busy[instr.rd][c]) begin
				free_copy = back_end_pkg::copy_t'(c);
				free_found = 1'b1;
			end
		end
	end

	assign o_instr_fifo_pop = !i_instr_fifo_empty && !i_issue_full && !i_rob_full
		&& (!rd_en || free_found);

	assign o_issue_push = o_instr_fifo_pop;
	assign o_rob_push = o_instr_fifo_pop;

	assign o_issue_info.op = instr.op;
	assign o_issue_info.imm = instr.imm;
	assign o_issue_info.rd_phy.areg = instr.rd;
	assign o_issue_info.rd_phy.copy = rd_en ? free_copy : '0;
	// sources read the current rename-active copy, x0 is copy 0
	assign o_issue_info.rs1_phy.areg = instr.rs1;
	assign o_issue_info.rs1_phy.copy = (instr.rs1 == '0) ? '0 : i_rn_act[instr.rs1];
	assign o_issue_info.rs2_phy.areg = instr.rs2;
	assign o_issue_info.rs2_phy.copy = (instr.rs2 == '0) ? '0 : i_rn_act[instr.rs2];

	assign o_rob_info.rd = instr.rd;
	assign o_rob_info.rd_copy = o_issue_info.rd_phy.copy;

	assign o_rename_set.valid = o_instr_fifo_pop && rd_en;
	assign o_rename_set.phy = o_issue_info.rd_phy;

endmodule

//--- source/back_end_pkg.sv
// back end shared types
package back_end_pkg;

	localparam int XLEN   = 32;
	localparam int NREG   = 8;
	localparam int RP     = 4;
	localparam int ROB_AW = 3;
	localparam int IQ_AW  = 2;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [$clog2(NREG)-1:0] areg_t;
	typedef logic [$clog2(RP)-1:0] copy_t;

	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_addi = 3'd5
	} alu_op_e;

	// one physical register, architectural number plus copy
	typedef struct packed {
		areg_t areg;
		copy_t copy;
	} phy_idx_t;

	typedef struct packed {
		alu_op_e op;
		areg_t   rd;
		areg_t   rs1;
		areg_t   rs2;
		data_t   imm;
	} micro_instr_t;

	typedef struct packed {
		alu_op_e  op;
		phy_idx_t rd_phy;
		phy_idx_t rs1_phy;
		phy_idx_t rs2_phy;
		data_t    imm;
	} issue_info_t;

	typedef struct packed {
		alu_op_e  op;
		phy_idx_t rd_phy;
		data_t    src1;
		data_t    src2;
	} exe_param_t;

	typedef struct packed {
		areg_t rd;
		copy_t rd_copy;
	} reorder_info_t;

	// rename request from dispatch
	typedef struct packed {
		logic     valid;
		phy_idx_t phy;
	} rename_set_t;

endpackage
